// ==== hdl/data_memory.sv ====
`default_nettype none

module data_memory (
   input  wire logic                             i_clk,
   input  wire logic                             i_rst_n,
   mem_req_if.target                             req,
   input  wire logic                             i_debug_sel,   // Debug read has priority
   input  wire logic [mem_pkg::DMEM_WORDS_W-1:0] i_debug_addr,
   output logic [mem_pkg::DATA_W-1:0]            o_rdata,       // Whole addressed word
   output logic                                  o_fault,       // Misaligned access seen
   output logic [mem_pkg::DATA_W-1:0]            o_debug_data
);
   import mem_pkg::*;

   localparam int DEPTH = 2 ** DMEM_WORDS_W;

   logic [DATA_W-1:0]       mem [DEPTH];
   logic [DMEM_WORDS_W-1:0] word_idx;
   logic [1:0]              lane_ofs;
   logic                    is_mmio;
   logic                    st_misalign;
   logic                    ld_misalign;
   logic [NB_LANES-1:0]     lane_we;
   logic [DATA_W-1:0]       wdata_al;
   logic                    capture;

   // Halfword needs bit 0 clear, word needs both low bits clear
   function automatic logic misaligned(input size_t size, input logic [1:0] ofs);
      logic bad;
      case (size)
         SIZE_HALF: bad = ofs[0];
         SIZE_WORD: bad = |ofs;
         default:   bad = 1'b0;  // Bytes fit any lane
      endcase
      return bad;
   endfunction

   assign word_idx    = req.addr[DMEM_WORDS_W+1:2];
   assign lane_ofs    = req.addr[1:0];
   assign is_mmio     = req.addr[MMIO_BIT];  // Register block owns this region
   assign st_misalign = misaligned(req.store_size, lane_ofs);
   assign ld_misalign = misaligned(req.load_size, lane_ofs);

   // Read side only runs when the stage is latching and no debug read is up
   assign capture = req.ce && (req.load_size != SIZE_NONE) && !i_debug_sel;

   // Move the store data up to its lane
   assign wdata_al = req.wdata << (LANE_W * lane_ofs);

   // Lane enables from size and offset
   always_comb begin
      lane_we = '0;
      if (!is_mmio && !st_misalign) begin
         case (req.store_size)
            SIZE_BYTE: lane_we = 4'b0001 << lane_ofs;
            SIZE_HALF: lane_we = lane_ofs[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: lane_we = 4'b1111;
            default:   lane_we = 4'b0000;
         endcase
      end
   end

   // Memory starts cleared
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Byte-lane write
   always_ff @(posedge i_clk) begin
      for (int l = 0; l < NB_LANES; l++) begin
         if (lane_we[l]) begin
            mem[word_idx][l*LANE_W +: LANE_W] <= wdata_al[l*LANE_W +: LANE_W];
         end
      end
   end

   // Registered read, old word on a same-cycle write
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rdata <= '0;
         o_fault <= 1'b0;
      end else if (capture) begin
         o_rdata <= mem[word_idx];
         o_fault <= !is_mmio && (ld_misalign || st_misalign);  // MMIO ignores low bits
      end
   end

   // Debug port, independent word address
   always_ff @(posedge i_clk) begin
      if (i_debug_sel) begin
         o_debug_data <= mem[i_debug_addr];
      end
   end

   // Only the aligned byte, halfword and word patterns may ever reach the array
   a_lane_legal: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      lane_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                      4'b0011, 4'b1100, 4'b1111}
   ) else $error("data_memory: illegal lane enable %b", lane_we);

   // Stores meant for the register block never touch the array
   a_mmio_no_write: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      is_mmio |-> (lane_we == '0)
   ) else $error("data_memory: write enable in MMIO region");

endmodule

`default_nettype wire

// ==== hdl/load_mux.sv ====
`default_nettype none

module load_mux (
   input  wire logic                       i_clk,
   input  wire logic                       i_rst_n,
   mem_req_if.combiner                     req,
   input  wire logic                       i_debug_sel,   // Blocks normal loads
   input  wire logic [mem_pkg::DATA_W-1:0] i_mem_rdata,   // From data memory
   input  wire logic [mem_pkg::DATA_W-1:0] i_mmio_rdata,  // From register block
   input  wire logic                       i_mem_fault,
   output logic [mem_pkg::DATA_W-1:0]      o_load_data,
   output logic                            o_load_valid,
   output logic                            o_fault
);
   import mem_pkg::*;

   logic              capture;
   logic              mmio_q;     // Region of the latched load
   logic [1:0]        ofs_q;      // Lane offset of the latched load
   size_t             size_q;
   logic              signed_q;
   logic [DATA_W-1:0] shifted;
   logic [DATA_W-1:0] extended;

   // Same capture rule as the targets
   assign capture = req.ce && (req.load_size != SIZE_NONE) && !i_debug_sel;

   // Request attributes, held while ce is low
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mmio_q   <= 1'b0;
         ofs_q    <= 2'b00;
         size_q   <= SIZE_NONE;
         signed_q <= 1'b0;
      end else if (capture) begin
         mmio_q   <= req.addr[MMIO_BIT];
         ofs_q    <= req.addr[1:0];
         size_q   <= req.load_size;
         signed_q <= req.load_signed;
      end
   end

   // One-cycle valid per captured load
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_load_valid <= 1'b0;
      end else begin
         o_load_valid <= capture;
      end
   end

   // Bring the addressed lane down to bit 0
   assign shifted = i_mem_rdata >> (LANE_W * ofs_q);

   always_comb begin
      case (size_q)
         SIZE_BYTE: extended = {{(DATA_W - LANE_W){signed_q & shifted[LANE_W-1]}},
                                shifted[LANE_W-1:0]};
         SIZE_HALF: extended = {{(DATA_W - 2*LANE_W){signed_q & shifted[2*LANE_W-1]}},
                                shifted[2*LANE_W-1:0]};
         SIZE_WORD: extended = shifted;   // Offset is zero for an aligned word
         default:   extended = '0;
      endcase
   end

   // MMIO words unchanged, faulted memory loads read zero
   always_comb begin
      if (mmio_q) begin
         o_load_data = i_mmio_rdata;
      end else if (i_mem_fault) begin
         o_load_data = '0;
      end else begin
         o_load_data = extended;
      end
   end

   assign o_fault = o_load_valid && !mmio_q && i_mem_fault;

   // Fault only on a fresh result, with the data forced to zero
   a_fault_valid: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      o_fault |-> (o_load_valid && (o_load_data == '0))
   ) else $error("load_mux: fault without valid zero result");

endmodule

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

   // Address map
   localparam int ADDR_W       = 11;  // Byte address width
   localparam int MMIO_BIT     = 10;  // Set selects the register block
   localparam int DMEM_WORDS_W = 8;   // 256 words of data memory

   // Data path
   localparam int DATA_W   = 32;
   localparam int NB_LANES = 4;
   localparam int LANE_W   = DATA_W / NB_LANES;  // One byte per lane

   // Word offsets inside the MMIO region, taken from addr[MMIO_BIT-1:2]
   localparam logic [DMEM_WORDS_W-1:0] MMIO_GPIO_OFS  = 8'd0;  // Output register
   localparam logic [DMEM_WORDS_W-1:0] MMIO_COUNT_OFS = 8'd1;  // Free-running counter

   // Access size, same code for store size and load size
   typedef enum logic [1:0] {
      SIZE_NONE = 2'b00,  // No access
      SIZE_BYTE = 2'b01,
      SIZE_HALF = 2'b10,
      SIZE_WORD = 2'b11
   } size_t;

endpackage

`default_nettype wire

// ==== hdl/mem_req_if.sv ====
`default_nettype none

// One load/store request as it leaves the execute stage
interface mem_req_if;
   import mem_pkg::*;

   logic [ADDR_W-1:0] addr;         // Byte address, bit MMIO_BIT picks the region
   logic [DATA_W-1:0] wdata;        // Store data, right aligned
   size_t             store_size;   // SIZE_NONE means no store
   size_t             load_size;    // SIZE_NONE means no load
   logic              load_signed;  // Sign extend narrow loads
   logic              ce;           // Latch enable for the read side

   // Top level drives the request
   modport master (
      output addr,
      output wdata,
      output store_size,
      output load_size,
      output load_signed,
      output ce
   );

   // Data memory and register block, each decodes its own region
   modport target (
      input addr,
      input wdata,
      input store_size,
      input load_size,
      input ce
   );

   // Load combiner only looks at the read attributes
   modport combiner (
      input addr,
      input load_size,
      input load_signed,
      input ce
   );

endinterface

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`default_nettype none

module mem_stage (
   input  wire logic                             i_clk,
   input  wire logic                             i_rst_n,
   input  wire logic [mem_pkg::ADDR_W-1:0]       i_addr,         // Byte address from EX
   input  wire logic [mem_pkg::DATA_W-1:0]       i_wdata,
   input  wire mem_pkg::size_t                   i_store_size,
   input  wire mem_pkg::size_t                   i_load_size,
   input  wire logic                             i_load_signed,
   input  wire logic                             i_ce,           // Pipeline latch enable
   input  wire logic                             i_debug_sel,
   input  wire logic [mem_pkg::DMEM_WORDS_W-1:0] i_debug_addr,
   output logic [mem_pkg::DATA_W-1:0]            o_load_data,    // One cycle after capture
   output logic                                  o_load_valid,
   output logic                                  o_fault,
   output logic [mem_pkg::DATA_W-1:0]            o_debug_data,
   output logic [mem_pkg::DATA_W-1:0]            o_gpio
);
   import mem_pkg::*;

   logic [DATA_W-1:0] mem_rdata;
   logic [DATA_W-1:0] mmio_rdata;
   logic              mem_fault;

   mem_req_if req ();

   // Plain ports onto the request bundle
   assign req.addr        = i_addr;
   assign req.wdata       = i_wdata;
   assign req.store_size  = i_store_size;
   assign req.load_size   = i_load_size;
   assign req.load_signed = i_load_signed;
   assign req.ce          = i_ce;

   // Byte-lane RAM with debug read
   data_memory u_data_memory (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .req          (req.target),
      .i_debug_sel  (i_debug_sel),
      .i_debug_addr (i_debug_addr),
      .o_rdata      (mem_rdata),
      .o_fault      (mem_fault),
      .o_debug_data (o_debug_data)
   );

   // GPIO and cycle counter
   mmio_regs u_mmio_regs (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .req     (req.target),
      .o_rdata (mmio_rdata),
      .o_gpio  (o_gpio)
   );

   // Lane select and extension
   load_mux u_load_mux (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .req          (req.combiner),
      .i_debug_sel  (i_debug_sel),
      .i_mem_rdata  (mem_rdata),
      .i_mmio_rdata (mmio_rdata),
      .i_mem_fault  (mem_fault),
      .o_load_data  (o_load_data),
      .o_load_valid (o_load_valid),
      .o_fault      (o_fault)
   );

endmodule

`default_nettype wire

// ==== hdl/mmio_regs.sv ====
`default_nettype none

module mmio_regs (
   input  wire logic                  i_clk,
   input  wire logic                  i_rst_n,
   mem_req_if.target                  req,
   output logic [mem_pkg::DATA_W-1:0] o_rdata,  // Registered read word
   output logic [mem_pkg::DATA_W-1:0] o_gpio    // General-purpose output
);
   import mem_pkg::*;

   logic [DMEM_WORDS_W-1:0] word_ofs;
   logic                    is_mmio;
   logic                    gpio_we;
   logic                    capture;
   logic [DATA_W-1:0]       cycle_cnt;
   logic [DATA_W-1:0]       cnt_next;
   logic [DATA_W-1:0]       rd_word;

   assign word_ofs = req.addr[MMIO_BIT-1:2];  // Low bits ignored here
   assign is_mmio  = req.addr[MMIO_BIT];

   // Any store size writes the full word
   assign gpio_we = is_mmio && (req.store_size != SIZE_NONE) && (word_ofs == MMIO_GPIO_OFS);
   assign capture = is_mmio && req.ce && (req.load_size != SIZE_NONE);

   assign cnt_next = cycle_cnt + 1'b1;  // Count includes the current edge

   // Read mux, unmapped offsets give zero
   always_comb begin
      case (word_ofs)
         MMIO_GPIO_OFS:  rd_word = o_gpio;     // Value before a same-edge store
         MMIO_COUNT_OFS: rd_word = cnt_next;
         default:        rd_word = '0;
      endcase
   end

   // Free-running edge counter
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cnt_next;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_gpio <= '0;
      end else if (gpio_we) begin
         o_gpio <= req.wdata;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rdata <= '0;
      end else if (capture) begin
         o_rdata <= rd_word;  // Holds while nothing is latched
      end
   end

   // Counter only moves forward between resets
   a_cnt_monotonic: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      cycle_cnt >= $past(cycle_cnt)
   ) else $error("mmio_regs: counter went backwards");

endmodule

`default_nettype wire

// ==== mips_mem.f ====
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/data_memory.sv
hdl/mmio_regs.sv
hdl/load_mux.sv
hdl/mem_stage.sv
testbench/tb_clock.sv
testbench/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mem_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_mem_stage -Mdir "$OBJ" -o vsim -f mips_mem.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/vsim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

grep -q "test failed" "$LOG"
if [ $? -eq 0 ]; then
   exit 1
fi

exit 0

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
   output logic o_clk
);
   timeunit 1ns;
   timeprecision 1ps;

   // 20 ns period
   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_stage.sv ====
`default_nettype none

module tb_mem_stage;
   timeunit 1ns;
   timeprecision 1ps;
   import mem_pkg::*;

   localparam int N_RAND = 16;                 // Random stores in the first pass
   localparam int N_OPS  = N_RAND * 7 + 40;    // Stores, six loads each, directed ops

   logic        clk;
   logic        rst_n;
   logic [10:0] addr;
   logic [31:0] wdata;
   size_t       store_size;
   size_t       load_size;
   logic        load_signed;
   logic        ce;
   logic        debug_sel;
   logic [7:0]  debug_addr;
   logic [31:0] o_load_data;
   logic        o_load_valid;
   logic        o_fault;
   logic [31:0] o_debug_data;
   logic [31:0] o_gpio;

   // Reference model
   logic [7:0]  shadow [1024];  // Byte image of data memory
   logic [31:0] gpio_model;
   logic [31:0] edge_cnt;       // Edges since reset release
   logic [31:0] rng;
   logic [10:0] st_addr [N_RAND];

   // Expectation for the op driven this cycle, then one edge later
   logic        exp_valid;
   logic        exp_fault;
   logic [31:0] exp_data;
   logic        dbg_valid;
   logic [31:0] dbg_exp;
   logic        load_q;
   logic        fault_q;
   logic [31:0] data_q;         // Holds while no load is captured
   logic        dbg_q;
   logic [31:0] dbg_exp_q;
   logic [31:0] gpio_q;
   int          errors;
   int          n_loads;
   int          n_debug;

   tb_clock u_clock (.o_clk(clk));

   mem_stage DUT (
      .i_clk         (clk),
      .i_rst_n       (rst_n),
      .i_addr        (addr),
      .i_wdata       (wdata),
      .i_store_size  (store_size),
      .i_load_size   (load_size),
      .i_load_signed (load_signed),
      .i_ce          (ce),
      .i_debug_sel   (debug_sel),
      .i_debug_addr  (debug_addr),
      .o_load_data   (o_load_data),
      .o_load_valid  (o_load_valid),
      .o_fault       (o_fault),
      .o_debug_data  (o_debug_data),
      .o_gpio        (o_gpio)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Halfwords on even bytes, words on multiples of four
   function automatic logic bad_align(input logic [10:0] a, input size_t sz);
      return (sz == SIZE_HALF && a[0]) || (sz == SIZE_WORD && a[1:0] != 2'b00);
   endfunction

   function automatic logic [10:0] align(input logic [10:0] a, input size_t sz);
      logic [10:0] r;
      case (sz)
         SIZE_HALF: r = {a[10:1], 1'b0};
         SIZE_WORD: r = {a[10:2], 2'b00};
         default:   r = a;
      endcase
      return r;
   endfunction

   function automatic logic [31:0] expected_load(input logic [10:0] a, input size_t sz,
                                                 input logic sgn);
      logic [9:0]  b;
      logic [15:0] h;
      logic [31:0] r;
      b = a[9:0];
      h = {shadow[b + 10'd1], shadow[b]};
      r = '0;
      if (a[10]) begin
         case (a[9:2])                        // MMIO, size and low bits ignored
            8'd0:    r = gpio_model;
            8'd1:    r = edge_cnt + 32'd1;    // Capture edge counts too
            default: r = '0;
         endcase
      end else if (!bad_align(a, sz)) begin
         case (sz)
            SIZE_BYTE: r = {{24{sgn & shadow[b][7]}}, shadow[b]};
            SIZE_HALF: r = {{16{sgn & h[15]}}, h};
            SIZE_WORD: r = {shadow[b + 10'd3], shadow[b + 10'd2], h};
            default:   r = '0;
         endcase
      end
      return r;
   endfunction

   task automatic clear_op();
      store_size  = SIZE_NONE;
      load_size   = SIZE_NONE;
      load_signed = 1'b0;
      ce          = 1'b1;
      debug_sel   = 1'b0;
      exp_valid   = 1'b0;
      exp_fault   = 1'b0;
      dbg_valid   = 1'b0;
   endtask

   task automatic idle_op();
      @(negedge clk);
      clear_op();
   endtask

   task automatic store_op(input logic [10:0] a, input logic [31:0] d, input size_t sz);
      logic [9:0] b;
      b = a[9:0];
      @(negedge clk);
      clear_op();
      addr       = a;
      wdata      = d;
      store_size = sz;
      if (a[10]) begin
         if (a[9:2] == 8'd0) gpio_model = d;  // Whole word whatever the size
      end else if (!bad_align(a, sz)) begin
         shadow[b] = d[7:0];
         if (sz != SIZE_BYTE) shadow[b + 10'd1] = d[15:8];
         if (sz == SIZE_WORD) begin
            shadow[b + 10'd2] = d[23:16];
            shadow[b + 10'd3] = d[31:24];
         end
      end
   endtask

   task automatic load_op(input logic [10:0] a, input size_t sz, input logic sgn);
      @(negedge clk);
      clear_op();
      addr        = a;
      load_size   = sz;
      load_signed = sgn;
      exp_valid   = 1'b1;
      exp_fault   = !a[10] && bad_align(a, sz);
      exp_data    = expected_load(a, sz, sgn);
      n_loads++;
   endtask

   task automatic load_all_sizes(input logic [10:0] a);
      for (int sg = 0; sg < 2; sg++) begin
         load_op(align(a, SIZE_BYTE), SIZE_BYTE, sg[0]);
         load_op(align(a, SIZE_HALF), SIZE_HALF, sg[0]);
         load_op(align(a, SIZE_WORD), SIZE_WORD, sg[0]);
      end
   endtask

   task automatic ce_low_op(input logic [10:0] a, input size_t sz);
      @(negedge clk);
      clear_op();
      ce        = 1'b0;  // Load presented but not latched
      addr      = a;
      load_size = sz;
   endtask

   // Debug read with a competing load that must be ignored
   task automatic debug_op(input logic [7:0] widx, input logic [10:0] la);
      @(negedge clk);
      clear_op();
      debug_sel  = 1'b1;
      debug_addr = widx;
      addr       = la;
      load_size  = SIZE_WORD;
      dbg_valid  = 1'b1;
      dbg_exp    = {shadow[{widx, 2'd3}], shadow[{widx, 2'd2}],
                    shadow[{widx, 2'd1}], shadow[{widx, 2'd0}]};
      n_debug++;
   endtask

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         load_q    <= 1'b0;
         fault_q   <= 1'b0;
         data_q    <= '0;
         dbg_q     <= 1'b0;
         dbg_exp_q <= '0;
         gpio_q    <= '0;
         edge_cnt  <= '0;
      end else begin
         load_q    <= exp_valid;
         fault_q   <= exp_fault;
         if (exp_valid) data_q <= exp_data;
         dbg_q     <= dbg_valid;
         dbg_exp_q <= dbg_exp;
         gpio_q    <= gpio_model;
         edge_cnt  <= edge_cnt + 32'd1;
      end
   end

   a_valid: assert property (@(posedge clk) disable iff (!rst_n) load_q |-> o_load_valid)
      else begin
         errors++;
         $display("mismatch o_load_valid got %h exp %h", $sampled(o_load_valid), 1'b1);
      end

   // Data is checked every cycle, so a held value is covered too
   a_data: assert property (@(posedge clk) disable iff (!rst_n) o_load_data == data_q)
      else begin
         errors++;
         $display("mismatch o_load_data got %h exp %h", $sampled(o_load_data),
                  $sampled(data_q));
      end

   a_fault: assert property (@(posedge clk) disable iff (!rst_n)
                             load_q |-> (o_fault == fault_q))
      else begin
         errors++;
         $display("mismatch o_fault got %h exp %h", $sampled(o_fault), $sampled(fault_q));
      end

   a_idle: assert property (@(posedge clk) disable iff (!rst_n)
                            !load_q |-> (!o_load_valid && !o_fault))
      else begin
         errors++;
         $display("valid or fault raised although no load was captured");
      end

   a_debug: assert property (@(posedge clk) disable iff (!rst_n)
                             dbg_q |-> (o_debug_data == dbg_exp_q))
      else begin
         errors++;
         $display("mismatch o_debug_data got %h exp %h", $sampled(o_debug_data),
                  $sampled(dbg_exp_q));
      end

   a_gpio: assert property (@(posedge clk) disable iff (!rst_n) o_gpio == gpio_q)
      else begin
         errors++;
         $display("mismatch o_gpio got %h exp %h", $sampled(o_gpio), $sampled(gpio_q));
      end

   // Watchdog
   initial begin
      #((N_OPS + 20) * 20);
      $display("watchdog expired before the test sequence finished");
      $display("test failed");
      $finish;
   end

   initial begin
      logic [10:0] a;
      size_t       sz;
      addr        = '0;
      wdata       = '0;
      debug_addr  = '0;
      dbg_exp     = '0;
      exp_data    = '0;
      gpio_model  = '0;
      errors      = 0;
      n_loads     = 0;
      n_debug     = 0;
      rng         = 32'h8dd2_7780;
      rst_n       = 1'b0;
      clear_op();
      for (int i = 0; i < 1024; i++) begin
         shadow[i] = 8'h00;  // Memory starts cleared
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Random aligned stores, then every load flavour at each address
      for (int i = 0; i < N_RAND; i++) begin
         rng = xorshift(rng);
         case (rng[1:0])
            2'd0:    sz = SIZE_BYTE;
            2'd1:    sz = SIZE_HALF;
            default: sz = SIZE_WORD;
         endcase
         a          = align({1'b0, rng[13:4]}, sz);
         st_addr[i] = a;
         rng        = xorshift(rng);
         store_op(a, rng, sz);
      end
      for (int i = 0; i < N_RAND; i++) begin
         load_all_sizes(st_addr[i]);
      end

      // Misaligned stores write nothing, misaligned loads fault
      store_op(11'h040, 32'h8899_aabb, SIZE_WORD);
      store_op(11'h041, 32'h0000_1234, SIZE_HALF);
      store_op(11'h042, 32'hdead_beef, SIZE_WORD);
      load_op(11'h043, SIZE_HALF, 1'b1);
      load_op(11'h041, SIZE_WORD, 1'b0);
      load_op(11'h040, SIZE_WORD, 1'b0);
      load_op(11'h041, SIZE_BYTE, 1'b1);

      // Latch enable low holds the result
      load_op(11'h040, SIZE_HALF, 1'b1);
      repeat (3) ce_low_op(11'h042, SIZE_HALF);
      load_op(11'h042, SIZE_BYTE, 1'b0);

      // Debug reads block normal loads
      for (int i = 0; i < 4; i++) begin
         debug_op(st_addr[i][9:2], align(st_addr[i], SIZE_WORD));
      end
      idle_op();

      // MMIO: GPIO, no aliasing into word 0, counter, unmapped offsets
      rng = xorshift(rng);
      store_op(11'h400, rng, SIZE_WORD);
      load_op(11'h400, SIZE_WORD, 1'b0);
      rng = xorshift(rng);
      store_op(11'h402, rng, SIZE_BYTE);
      load_op(11'h400, SIZE_BYTE, 1'b1);
      load_op(11'h000, SIZE_WORD, 1'b0);
      load_op(11'h404, SIZE_WORD, 1'b0);
      repeat (3) idle_op();
      load_op(11'h405, SIZE_HALF, 1'b0);    // Four edges after the first read
      store_op(11'h404, 32'hffff_ffff, SIZE_WORD);  // Counter is read-only
      load_op(11'h404, SIZE_WORD, 1'b0);
      load_op(11'h408, SIZE_WORD, 1'b0);
      load_op(11'h7fc, SIZE_WORD, 1'b0);
      idle_op();
      idle_op();
      @(posedge clk);
      @(negedge clk);

      $display("loads=%0d debug_reads=%0d errors=%0d", n_loads, n_debug, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
